// File: test/cw_test_patterns.txt
// op reg byte data aux, all hex. 1 write, 2 read (aux mask), 3 wait status bit (aux limit)
// 4 DIP, 5 stuck bit at 1, 6 clear stuck, 7 LEDs (aux mask), 8 LED0 toggle, 9 iter grows, 0 end
01 00 00 5a 00   // LEDs
07 00 00 5a ff
02 00 00 5a ff
01 01 00 80 00   // Control, test still off
02 01 00 80 ff
01 02 00 03 00   // SRAM top
02 02 00 03 ff
02 06 00 00 ff   // Unmapped register
02 00 01 00 ff   // Unmapped byte
04 00 00 c3 00
02 04 00 c3 ff
01 01 00 01 00   // Fault-free run
03 03 00 00 190
02 03 00 01 03
09 05 00 00 190
09 05 00 00 190
01 01 00 00 00   // Disable clears results
02 03 00 00 07
02 05 00 00 ff
02 05 01 00 ff
05 00 00 03 00   // Stuck bit 3
01 01 00 01 00
03 03 00 01 190
02 03 00 02 07
01 01 00 00 00
02 03 00 00 07
01 01 00 03 00   // Heartbeat view with fail
03 03 00 01 190
07 00 00 04 fe
01 01 00 00 00
06 00 00 00 00
01 01 00 03 00   // Heartbeat view with pass
03 03 00 00 190
07 00 00 02 fe
08 00 00 00 28
00 00 00 00 00

// File: cw_test.f
verilog/cw_test_pkg.sv
verilog/usb_reg_fe.sv
verilog/test_regs.sv
verilog/sram_rwtest.sv
verilog/led_driver.sv
verilog/cw_test_top.sv
test/sram_model.sv
test/tb_cw_test_top.sv

// File: Bender.yml
package:
  name: cw_test

sources:
  - files:
      - verilog/cw_test_pkg.sv
      - verilog/usb_reg_fe.sv
      - verilog/test_regs.sv
      - verilog/sram_rwtest.sv
      - verilog/led_driver.sv
      - verilog/cw_test_top.sv
  - target: test
    files:
      - test/sram_model.sv
      - test/tb_cw_test_top.sv

// File: test/tb_cw_test_top.sv
`timescale 1ns/1ps

module tb_cw_test_top import cw_test_pkg::*; ();

   localparam int TB_SRAM_ADDR_W = 10;
   localparam int TB_HB_W        = 4;
   localparam int MAX_OPS        = 64;

   logic      usb_clk_buf;
   logic      reset;
   byte_t     usb_data_in;
   byte_t     usb_data_out;
   logic      usb_data_oe;
   usb_addr_t usb_addr;
   logic      usb_rdn;
   logic      usb_wrn;
   logic      usb_cen;
   byte_t     dip;
   byte_t     leds;
   logic [TB_SRAM_ADDR_W-1:0] sram_addr;
   byte_t     sram_rdata;
   byte_t     sram_wdata;
   logic      sram_data_oe;
   logic      sram_wen;
   logic      sram_oen;
   logic      sram_cen;
   logic      sram_ce2;
   logic      stuck_en;
   logic [2:0] stuck_bit;

   logic [15:0] pat [0:5*MAX_OPS-1]; // op, reg, byte, data, aux per command
   int   cycle_cnt     = 0;
   int   timeout_limit = 0;
   int   pass_cnt;                   // Write sweeps seen since the last disable
   int   last_iter;
   logic wen_was_low   = 1'b0;

   cw_test_top #(
      .SRAM_ADDR_W (TB_SRAM_ADDR_W),
      .HB_W        (TB_HB_W)
   ) DUT (
      .usb_clk_buf (usb_clk_buf), .reset (reset),
      .usb_data_i (usb_data_in), .usb_data_o (usb_data_out), .usb_data_oe_o (usb_data_oe),
      .usb_addr_i (usb_addr), .usb_rdn_i (usb_rdn), .usb_wrn_i (usb_wrn), .usb_cen_i (usb_cen),
      .dip_i (dip), .leds_o (leds),
      .sram_addr_o (sram_addr), .sram_data_i (sram_rdata), .sram_data_o (sram_wdata),
      .sram_data_oe_o (sram_data_oe), .sram_wen_o (sram_wen), .sram_oen_o (sram_oen),
      .sram_cen_o (sram_cen), .sram_ce2_o (sram_ce2)
   );

   sram_model #(.ADDR_W (TB_SRAM_ADDR_W)) u_sram (
      .addr_i (sram_addr), .data_i (sram_wdata), .wen_i (sram_wen), .oen_i (sram_oen),
      .cen_i (sram_cen), .ce2_i (sram_ce2), .stuck_en_i (stuck_en),
      .stuck_bit_i (stuck_bit), .data_o (sram_rdata)
   );

   initial begin
      usb_clk_buf = 1'b0;
      forever #5 usb_clk_buf = ~usb_clk_buf;
   end

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("Test FAILED");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                        input string what);
      if (actual !== expected)
         fail_run($sformatf("FAILED at %0t: %s, got %0h, expected %0h",
                            $time, what, actual, expected));
   endtask

   always @(posedge usb_clk_buf) begin
      cycle_cnt <= cycle_cnt + 1;
      if (timeout_limit != 0 && cycle_cnt > timeout_limit)
         fail_run($sformatf("Timeout: run still going after %0d cycles", cycle_cnt));
   end

   // Every finished SRAM write must leave address XOR pass number in the model
   always @(negedge usb_clk_buf) begin
      if (!reset && !sram_wen)
         check(sram_data_oe, 1'b1, "SRAM data drive during write strobe");
      if (!reset && !sram_oen)
         check(sram_data_oe, 1'b0, "SRAM data drive during read"); // Model owns the bus here
      if (!reset && wen_was_low && sram_wen && !sram_cen && sram_ce2) begin
         if (sram_addr == '0)
            pass_cnt = pass_cnt + 1; // A sweep always starts at address 0
         check(u_sram.mem[sram_addr], sram_addr[7:0] ^ pass_cnt[7:0], "SRAM word after write");
      end
      wen_was_low = !sram_wen;
   end

   task automatic bus_write(input reg_addr_t r, input bytecnt_t b, input byte_t d);
      @(posedge usb_clk_buf);
      usb_addr    <= {r, b};
      usb_data_in <= d;
      @(posedge usb_clk_buf);
      usb_cen <= 1'b0;
      usb_wrn <= 1'b0;
      repeat (3) @(posedge usb_clk_buf);
      usb_wrn <= 1'b1;
      usb_cen <= 1'b1;
      repeat (3) @(posedge usb_clk_buf); // Register updated by now
   endtask

   task automatic bus_read(input reg_addr_t r, input bytecnt_t b, output byte_t d);
      @(posedge usb_clk_buf);
      usb_addr <= {r, b};
      @(posedge usb_clk_buf);
      usb_cen <= 1'b0;
      usb_rdn <= 1'b0;
      repeat (4) @(posedge usb_clk_buf);
      @(negedge usb_clk_buf);
      check(usb_data_oe, 1'b1, "read data enable");
      d = usb_data_out;
      @(posedge usb_clk_buf);
      usb_rdn <= 1'b1;
      usb_cen <= 1'b1;
      repeat (3) @(posedge usb_clk_buf);
   endtask

   task automatic read_iteration(output iter_t it);
      byte_t lo;
      byte_t hi;
      bus_read(REG_SRAM_ITER, 'd0, lo); // Low byte first
      bus_read(REG_SRAM_ITER, 'd1, hi);
      it = {hi, lo};
   endtask

   task automatic wait_status_bit(input int bit_pos, input int limit);
      int    start;
      byte_t st;
      start = cycle_cnt;
      bus_read(REG_STATUS, 'd0, st);
      while (!st[bit_pos]) begin
         if (cycle_cnt - start > limit)
            fail_run($sformatf("Status bit %0d was not set within %0d cycles", bit_pos, limit));
         bus_read(REG_STATUS, 'd0, st);
      end
   endtask

   task automatic wait_iter_growth(input int limit);
      int    start;
      iter_t it;
      start = cycle_cnt;
      read_iteration(it);
      while (it <= last_iter) begin
         if (cycle_cnt - start > limit)
            fail_run($sformatf("Iteration count stuck at %0d for %0d cycles", it, limit));
         read_iteration(it);
      end
      last_iter = it;
   endtask

   task automatic wait_led_toggle(input int limit);
      logic first;
      int   n;
      @(negedge usb_clk_buf);
      first = leds[0];
      n     = 0;
      while (leds[0] === first) begin
         if (n > limit)
            fail_run($sformatf("LED 0 did not toggle within %0d cycles", limit));
         @(negedge usb_clk_buf);
         n++;
      end
   endtask

   // Wait limits plus a fixed budget per register access
   function automatic int timeout_from_patterns();
      int total;
      total = 100;
      for (int i = 0; i < MAX_OPS && pat[5*i] !== 16'h0; i++) begin
         case (pat[5*i])
            16'h1, 16'h2: total += 100;
            16'h3, 16'h8: total += pat[5*i+4];
            16'h9:        total += 200 + pat[5*i+4];
            default:      total += 10;
         endcase
      end
      return total;
   endfunction

   task automatic run_patterns();
      logic [15:0] op;
      logic [15:0] val;
      logic [15:0] aux;
      reg_addr_t   r;
      bytecnt_t    b;
      byte_t       rd;
      int          i;
      i  = 0;
      op = pat[0];
      while (op !== 16'h0) begin
         r   = reg_addr_t'(pat[5*i+1]);
         b   = bytecnt_t'(pat[5*i+2]);
         val = pat[5*i+3];
         aux = pat[5*i+4];
         case (op)
            16'h1: begin
               bus_write(r, b, val[7:0]);
               if (r == REG_CTRL && !val[CTRL_SRAM_EN]) begin
                  pass_cnt  = -1; // Engine back in idle, next sweep is pass 0
                  last_iter = 0;
               end
            end
            16'h2: begin
               bus_read(r, b, rd);
               check(rd & aux[7:0], val[7:0], $sformatf("register %0d byte %0d", r, b));
            end
            16'h3: wait_status_bit(val[2:0], aux);
            16'h4: begin
               @(posedge usb_clk_buf);
               dip <= val[7:0];
            end
            16'h5: begin
               @(posedge usb_clk_buf);
               stuck_bit <= val[2:0];
               stuck_en  <= 1'b1;
            end
            16'h6: begin
               @(posedge usb_clk_buf);
               stuck_en <= 1'b0;
            end
            16'h7: begin
               @(negedge usb_clk_buf);
               check(leds & aux[7:0], val[7:0], "LED outputs");
            end
            16'h8: wait_led_toggle(aux);
            16'h9: wait_iter_growth(aux);
            default: fail_run($sformatf("Unknown operation %0h in pattern line %0d", op, i));
         endcase
         i++;
         op = (i < MAX_OPS) ? pat[5*i] : 16'h0;
      end
   endtask

   initial begin
      reset       = 1'b1;
      usb_data_in = '0;
      usb_addr    = '0;
      usb_rdn     = 1'b1;
      usb_wrn     = 1'b1;
      usb_cen     = 1'b1;
      dip         = '0;
      stuck_en    = 1'b0;
      stuck_bit   = '0;
      pass_cnt    = -1;
      last_iter   = 0;
      $readmemh("test/cw_test_patterns.txt", pat);
      timeout_limit = timeout_from_patterns();
      repeat (10) @(posedge usb_clk_buf);
      reset <= 1'b0;
      run_patterns();
      $display("Test OK");
      $finish;
   end

endmodule

// File: test/sram_model.sv
`timescale 1ns/1ps

module sram_model import cw_test_pkg::*; #(
   parameter int ADDR_W = 10
) (
   input  logic [ADDR_W-1:0] addr_i,
   input  byte_t             data_i,
   input  logic              wen_i,
   input  logic              oen_i,
   input  logic              cen_i,
   input  logic              ce2_i,
   input  logic              stuck_en_i,
   input  logic [2:0]        stuck_bit_i,
   output byte_t             data_o
);

   byte_t mem [0:(1<<ADDR_W)-1];
   logic  selected;
   byte_t stuck_mask;

   // Power-up contents differ for every address
   initial begin
      int fill;
      for (int a = 0; a < (1 << ADDR_W); a++) begin
         fill   = a ^ (a >> 8) ^ 'h5a;
         mem[a] = fill[7:0];
      end
   end

   assign selected = !cen_i && ce2_i;

   always @(posedge wen_i) begin
      if (selected)
         mem[addr_i] <= data_i; // Data latched at the end of the write strobe
   end

   // Stuck-at-one fault on the read path only
   assign stuck_mask = stuck_en_i ? (8'h01 << stuck_bit_i) : 8'h00;
   assign data_o     = (selected && !oen_i) ? (mem[addr_i] | stuck_mask) : 'z;

endmodule

// File: verilog/cw_test_top.sv
`timescale 1ns/1ps

module cw_test_top import cw_test_pkg::*; #(
   parameter int SRAM_ADDR_W = 20,
   parameter int HB_W        = 25
) (
   input  logic                   usb_clk_buf,
   input  logic                   reset,
   // USB register bus
   input  byte_t                  usb_data_i,
   output byte_t                  usb_data_o,
   output logic                   usb_data_oe_o,
   input  usb_addr_t              usb_addr_i,
   input  logic                   usb_rdn_i,
   input  logic                   usb_wrn_i,
   input  logic                   usb_cen_i,
   // Board I/O
   input  byte_t                  dip_i,
   output byte_t                  leds_o,
   // External SRAM
   output logic [SRAM_ADDR_W-1:0] sram_addr_o,
   input  byte_t                  sram_data_i,
   output byte_t                  sram_data_o,
   output logic                   sram_data_oe_o,
   output logic                   sram_wen_o,
   output logic                   sram_oen_o,
   output logic                   sram_cen_o,
   output logic                   sram_ce2_o
);

   reg_bus_t reg_bus;
   byte_t    reg_rdata;
   byte_t    reg_leds;
   logic     hb_sel;
   logic     sram_en;
   byte_t    sram_top;
   logic     sram_pass;
   logic     sram_fail;
   logic     sram_busy;
   iter_t    sram_iter;

   usb_reg_fe u_usb_reg_fe (
      .usb_clk_buf   (usb_clk_buf),
      .reset         (reset),
      .usb_data_i    (usb_data_i),
      .usb_addr_i    (usb_addr_i),
      .usb_rdn_i     (usb_rdn_i),
      .usb_wrn_i     (usb_wrn_i),
      .usb_cen_i     (usb_cen_i),
      .reg_rdata_i   (reg_rdata),
      .usb_data_o    (usb_data_o),
      .usb_data_oe_o (usb_data_oe_o),
      .reg_bus_o     (reg_bus)
   );

   test_regs u_test_regs (
      .usb_clk_buf (usb_clk_buf),
      .reset       (reset),
      .reg_bus_i   (reg_bus),
      .dip_i       (dip_i),
      .sram_pass_i (sram_pass),
      .sram_fail_i (sram_fail),
      .sram_busy_i (sram_busy),
      .sram_iter_i (sram_iter),
      .reg_rdata_o (reg_rdata),
      .leds_o      (reg_leds),
      .hb_sel_o    (hb_sel),
      .sram_en_o   (sram_en),
      .sram_top_o  (sram_top)
   );

   sram_rwtest #(
      .SRAM_ADDR_W (SRAM_ADDR_W)
   ) u_sram_rwtest (
      .usb_clk_buf    (usb_clk_buf),
      .reset          (reset),
      .active_i       (sram_en),
      .top_i          (sram_top),
      .sram_data_i    (sram_data_i),
      .sram_addr_o    (sram_addr_o),
      .sram_data_o    (sram_data_o),
      .sram_data_oe_o (sram_data_oe_o),
      .sram_wen_o     (sram_wen_o),
      .sram_oen_o     (sram_oen_o),
      .sram_cen_o     (sram_cen_o),
      .sram_ce2_o     (sram_ce2_o),
      .pass_o         (sram_pass),
      .fail_o         (sram_fail),
      .busy_o         (sram_busy),
      .iter_o         (sram_iter)
   );

   led_driver #(
      .HB_W (HB_W)
   ) u_led_driver (
      .usb_clk_buf (usb_clk_buf),
      .reset       (reset),
      .hb_sel_i    (hb_sel),
      .leds_i      (reg_leds),
      .sram_pass_i (sram_pass),
      .sram_fail_i (sram_fail),
      .leds_o      (leds_o)
   );

endmodule

// File: verilog/led_driver.sv
`timescale 1ns/1ps

module led_driver import cw_test_pkg::*; #(
   parameter int HB_W = 25
) (
   input  logic  usb_clk_buf,
   input  logic  reset,
   input  logic  hb_sel_i,
   input  byte_t leds_i,
   input  logic  sram_pass_i,
   input  logic  sram_fail_i,
   output byte_t leds_o
);

   logic [HB_W-1:0] hb_cnt;

   // Free-running, top bit blinks LED 0
   always_ff @(posedge usb_clk_buf) begin
      if (reset)
         hb_cnt <= '0;
      else
         hb_cnt <= hb_cnt + 1'b1;
   end

   always_comb begin
      if (hb_sel_i)
         leds_o = {5'b0, sram_fail_i, sram_pass_i, hb_cnt[HB_W-1]};
      else
         leds_o = leds_i; // Host-written value
   end

endmodule

// File: verilog/sram_rwtest.sv
`timescale 1ns/1ps

module sram_rwtest import cw_test_pkg::*; #(
   parameter int SRAM_ADDR_W = 20
) (
   input  logic                   usb_clk_buf,
   input  logic                   reset,
   input  logic                   active_i,
   input  byte_t                  top_i,
   input  byte_t                  sram_data_i,
   output logic [SRAM_ADDR_W-1:0] sram_addr_o,
   output byte_t                  sram_data_o,
   output logic                   sram_data_oe_o,
   output logic                   sram_wen_o,
   output logic                   sram_oen_o,
   output logic                   sram_cen_o,
   output logic                   sram_ce2_o,
   output logic                   pass_o,
   output logic                   fail_o,
   output logic                   busy_o,
   output iter_t                  iter_o
);

   sram_state_t            state;
   logic [SRAM_ADDR_W-1:0] addr_q;
   logic [SRAM_ADDR_W-1:0] last_addr;
   byte_t                  pattern;
   logic                   at_last;
   logic                   mismatch;

   // top_i gives the upper address byte, the rest runs to all ones
   assign last_addr = {top_i, {(SRAM_ADDR_W-8){1'b1}}};
   assign at_last   = (addr_q == last_addr);

   // Pattern changes each pass so stale data is caught
   assign pattern  = addr_q[7:0] ^ iter_o[7:0];
   assign mismatch = (sram_data_i != pattern);

   always_ff @(posedge usb_clk_buf) begin
      if (reset) begin
         state  <= SRAM_IDLE;
         addr_q <= '0;
         pass_o <= 1'b0;
         fail_o <= 1'b0;
         iter_o <= '0;
      end else if (!active_i) begin
         // Disable clears results as well
         state  <= SRAM_IDLE;
         addr_q <= '0;
         pass_o <= 1'b0;
         fail_o <= 1'b0;
         iter_o <= '0;
      end else begin
         case (state)
            SRAM_IDLE: begin
               addr_q <= '0;
               state  <= SRAM_WR_ADDR;
            end
            SRAM_WR_ADDR:   state <= SRAM_WR_STROBE;  // Address and data set up
            SRAM_WR_STROBE: state <= SRAM_WR_RELEASE; // WE low here
            SRAM_WR_RELEASE: begin
               if (at_last) begin
                  addr_q <= '0;
                  state  <= SRAM_RD_EN;
               end else begin
                  addr_q <= addr_q + 1'b1;
                  state  <= SRAM_WR_ADDR;
               end
            end
            SRAM_RD_EN: state <= SRAM_RD_CMP;
            SRAM_RD_CMP: begin
               if (mismatch) begin
                  fail_o <= 1'b1;
                  pass_o <= 1'b0;
                  state  <= SRAM_FAILED;
               end else if (at_last) begin
                  state <= SRAM_DONE;
               end else begin
                  addr_q <= addr_q + 1'b1;
                  state  <= SRAM_RD_EN;
               end
            end
            SRAM_DONE: begin
               pass_o <= 1'b1;
               iter_o <= iter_o + 1'b1;
               state  <= SRAM_IDLE;
            end
            SRAM_FAILED: state <= SRAM_FAILED; // Held until disabled
            default:     state <= SRAM_IDLE;
         endcase
      end
   end

   assign busy_o = (state != SRAM_IDLE) && (state != SRAM_DONE) && (state != SRAM_FAILED);

   // Pin decode from the state register
   assign sram_addr_o    = addr_q;
   assign sram_data_o    = pattern;
   assign sram_data_oe_o = (state == SRAM_WR_ADDR) || (state == SRAM_WR_STROBE) ||
                           (state == SRAM_WR_RELEASE);
   assign sram_wen_o     = (state != SRAM_WR_STROBE);
   assign sram_oen_o     = !((state == SRAM_RD_EN) || (state == SRAM_RD_CMP));
   assign sram_cen_o     = !busy_o;
   assign sram_ce2_o     = busy_o;

endmodule

// File: verilog/test_regs.sv
`timescale 1ns/1ps

module test_regs import cw_test_pkg::*; (
   input  logic     usb_clk_buf,
   input  logic     reset,
   input  reg_bus_t reg_bus_i,
   input  byte_t    dip_i,
   input  logic     sram_pass_i,
   input  logic     sram_fail_i,
   input  logic     sram_busy_i,
   input  iter_t    sram_iter_i,
   output byte_t    reg_rdata_o,
   output byte_t    leds_o,
   output logic     hb_sel_o,
   output logic     sram_en_o,
   output byte_t    sram_top_o
);

   byte_t leds_q;
   byte_t ctrl_q;
   byte_t top_q;
   byte_t status;
   byte_t rdata;
   logic  byte0;

   // All writable registers are one byte wide
   assign byte0 = (reg_bus_i.bytecnt == '0);

   always_ff @(posedge usb_clk_buf) begin
      if (reset) begin
         leds_q <= '0;
         ctrl_q <= '0;
         top_q  <= '0;
      end else if (reg_bus_i.wr && byte0) begin
         case (reg_bus_i.addr)
            REG_LEDS:     leds_q <= reg_bus_i.wdata;
            REG_CTRL:     ctrl_q <= reg_bus_i.wdata;
            REG_SRAM_TOP: top_q  <= reg_bus_i.wdata;
            default:      ; // Read-only or unmapped
         endcase
      end
   end

   always_comb begin
      status            = '0;
      status[STAT_PASS] = sram_pass_i;
      status[STAT_FAIL] = sram_fail_i;
      status[STAT_BUSY] = sram_busy_i;
   end

   // Read mux, zero for anything not mapped
   always_comb begin
      rdata = '0;
      case (reg_bus_i.addr)
         REG_LEDS:
            if (byte0) rdata = leds_q;
         REG_CTRL:
            if (byte0) rdata = ctrl_q;
         REG_SRAM_TOP:
            if (byte0) rdata = top_q;
         REG_STATUS:
            if (byte0) rdata = status;
         REG_DIP:
            if (byte0) rdata = dip_i;
         REG_SRAM_ITER: begin
            if (reg_bus_i.bytecnt == 'd0)
               rdata = sram_iter_i[7:0];   // Low byte first
            else if (reg_bus_i.bytecnt == 'd1)
               rdata = sram_iter_i[15:8];
         end
         default:
            rdata = '0;
      endcase
   end

   // Only drive data while a read is in progress
   assign reg_rdata_o = reg_bus_i.rd ? rdata : '0;

   assign leds_o     = leds_q;
   assign sram_en_o  = ctrl_q[CTRL_SRAM_EN];
   assign hb_sel_o   = ctrl_q[CTRL_HB_SEL];
   assign sram_top_o = top_q;

endmodule

// File: verilog/usb_reg_fe.sv
`timescale 1ns/1ps

module usb_reg_fe import cw_test_pkg::*; (
   input  logic      usb_clk_buf,
   input  logic      reset,
   input  byte_t     usb_data_i,
   input  usb_addr_t usb_addr_i,
   input  logic      usb_rdn_i,
   input  logic      usb_wrn_i,
   input  logic      usb_cen_i,
   input  byte_t     reg_rdata_i,
   output byte_t     usb_data_o,
   output logic      usb_data_oe_o,
   output reg_bus_t  reg_bus_o
);

   // Two-stage capture of the host strobes, all active low
   logic rdn_r1, rdn_r2;
   logic wrn_r1, wrn_r2;
   logic cen_r1, cen_r2;

   // Address and data follow the same two stages
   usb_addr_t addr_r1, addr_r2;
   byte_t     data_r1, data_r2;

   logic wr_q;
   logic rd;

   always_ff @(posedge usb_clk_buf) begin
      if (reset) begin
         rdn_r1 <= 1'b1;
         rdn_r2 <= 1'b1;
         wrn_r1 <= 1'b1;
         wrn_r2 <= 1'b1;
         cen_r1 <= 1'b1;
         cen_r2 <= 1'b1;
         wr_q   <= 1'b0;
      end else begin
         rdn_r1 <= usb_rdn_i;
         rdn_r2 <= rdn_r1;
         wrn_r1 <= usb_wrn_i;
         wrn_r2 <= wrn_r1;
         cen_r1 <= usb_cen_i;
         cen_r2 <= cen_r1;
         // One pulse per write cycle, on the falling edge of the strobe
         wr_q   <= wrn_r2 & ~wrn_r1 & ~cen_r1;
      end
   end

   always_ff @(posedge usb_clk_buf) begin
      addr_r1 <= usb_addr_i;
      addr_r2 <= addr_r1;
      data_r1 <= usb_data_i;
      data_r2 <= data_r1;
   end

   assign rd = ~rdn_r2 & ~cen_r2;

   // Upper address bits pick the register, lower bits the byte
   assign reg_bus_o.addr    = addr_r2[USB_ADDR_W-1:BYTECNT_W];
   assign reg_bus_o.bytecnt = addr_r2[BYTECNT_W-1:0];
   assign reg_bus_o.wdata   = data_r2;
   assign reg_bus_o.rd      = rd;
   assign reg_bus_o.wr      = wr_q;

   // Read-back path to the pad
   always_ff @(posedge usb_clk_buf) begin
      if (reset)
         usb_data_oe_o <= 1'b0;
      else
         usb_data_oe_o <= rd;
   end

   always_ff @(posedge usb_clk_buf) begin
      usb_data_o <= reg_rdata_i;
   end

endmodule

// File: verilog/cw_test_pkg.sv
package cw_test_pkg;

   // Bus geometry, fixed by the board
   localparam int USB_ADDR_W = 20;
   localparam int BYTECNT_W  = 7;

   typedef logic [7:0]                      byte_t;
   typedef logic [USB_ADDR_W-1:0]           usb_addr_t;
   typedef logic [USB_ADDR_W-BYTECNT_W-1:0] reg_addr_t;
   typedef logic [BYTECNT_W-1:0]            bytecnt_t;
   typedef logic [15:0]                     iter_t;

   // Front end to register block
   typedef struct packed {
      reg_addr_t addr;    // Register number
      bytecnt_t  bytecnt; // Byte within register
      byte_t     wdata;
      logic      rd;      // Level, held for the whole read
      logic      wr;      // Single-cycle pulse
   } reg_bus_t;

   // Register map
   localparam reg_addr_t REG_LEDS      = 'd0;
   localparam reg_addr_t REG_CTRL      = 'd1;
   localparam reg_addr_t REG_SRAM_TOP  = 'd2;
   localparam reg_addr_t REG_STATUS    = 'd3;
   localparam reg_addr_t REG_DIP       = 'd4;
   localparam reg_addr_t REG_SRAM_ITER = 'd5;

   // Control register bits
   localparam int CTRL_SRAM_EN = 0;
   localparam int CTRL_HB_SEL  = 1;

   // Status register bits
   localparam int STAT_PASS = 0;
   localparam int STAT_FAIL = 1;
   localparam int STAT_BUSY = 2;

   typedef enum logic [2:0] {
      SRAM_IDLE,
      SRAM_WR_ADDR,
      SRAM_WR_STROBE,
      SRAM_WR_RELEASE,
      SRAM_RD_EN,
      SRAM_RD_CMP,
      SRAM_DONE,
      SRAM_FAILED
   } sram_state_t;

endpackage
